// File: dv/tb_wb2sdrc.sv
// Wishbone to SDRAM bridge testbench
`timescale 1ns/100ps
`include "wb2sdrc_config.svh"

module tb_wb2sdrc;

  import wb2sdrc_pkg::*;

  localparam int CLK_PERIOD   = 100;
  // Outputs read a quarter period after the falling edge
  localparam int SAMPLE_DLY   = 25;
  localparam int TIMEOUT      = 50;
  localparam int RESET_CYCLES = 10;
  localparam int WATCHDOG     = 5000;

  logic       sdram_clk;
  logic       wb_clk_i;
  logic       wb_cyc_i;
  logic       wb_stb_i;
  logic       wb_we_i;
  wb_addr_t   wb_addr_i;
  wb_data_t   wb_dat_i;
  wb_sel_t    wb_sel_i;
  logic       wb_ack_o;
  wb_data_t   wb_dat_o;
  logic       sdr_req_o;
  wb_addr_t   sdr_req_addr_o;
  logic       sdr_req_wr_n_o;
  burst_len_t sdr_req_len_o;
  logic       sdr_req_ack_i;
  logic       sdr_wr_next_i;
  wb_sel_t    sdr_wr_en_n_o;
  wb_data_t   sdr_wr_data_o;
  logic       sdr_rd_valid_i;
  wb_data_t   sdr_rd_data_i;

  logic [31:0] lfsr_q;
  int          check_count;
  int          err_count;
  int          timeout_count;
  // Set once the responder has returned read data
  logic        rd_valid_sent;
  // Expected controller traffic in order
  sdr_cmd_t    exp_cmd_q[$];
  wr_beat_t    exp_beat_q[$];

  wb2sdrc u_dut (
    .sdram_clk      (sdram_clk),
    .wb_clk_i       (wb_clk_i),
    .wb_cyc_i       (wb_cyc_i),
    .wb_stb_i       (wb_stb_i),
    .wb_we_i        (wb_we_i),
    .wb_addr_i      (wb_addr_i),
    .wb_dat_i       (wb_dat_i),
    .wb_sel_i       (wb_sel_i),
    .wb_ack_o       (wb_ack_o),
    .wb_dat_o       (wb_dat_o),
    .sdr_req_o      (sdr_req_o),
    .sdr_req_addr_o (sdr_req_addr_o),
    .sdr_req_wr_n_o (sdr_req_wr_n_o),
    .sdr_req_len_o  (sdr_req_len_o),
    .sdr_req_ack_i  (sdr_req_ack_i),
    .sdr_wr_next_i  (sdr_wr_next_i),
    .sdr_wr_en_n_o  (sdr_wr_en_n_o),
    .sdr_wr_data_o  (sdr_wr_data_o),
    .sdr_rd_valid_i (sdr_rd_valid_i),
    .sdr_rd_data_i  (sdr_rd_data_i)
  );

  bind wb2sdrc wb2sdrc_assert u_assert (
    .sdram_clk   (sdram_clk),
    .wb_clk_i    (wb_clk_i),
    .cmd_push_i  (cmd_push),
    .cmd_full_i  (cmd_full),
    .cmd_pop_i   (sdr_req_ack_i),
    .cmd_empty_i (cmd_empty),
    .wr_push_i   (wr_push),
    .wr_full_i   (wr_full),
    .wr_pop_i    (sdr_wr_next_i),
    .wr_empty_i  (wr_empty),
    .rd_push_i   (sdr_rd_valid_i),
    .rd_full_i   (rd_full),
    .rd_pop_i    (rd_pop),
    .rd_empty_i  (rd_empty),
    .rd_cmd_i    (cmd_push & ~wb_we_i),
    .state_i     (u_ctrl.state_q)
  );

  initial begin
    sdram_clk = 1'b0;
    forever #(CLK_PERIOD / 2) sdram_clk = ~sdram_clk;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  // Galois LFSR shifting right
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] nxt;
    nxt = state >> 1;
    if (state[0]) begin
      nxt = nxt ^ 32'h8020_0003;
    end
    return nxt;
  endfunction

  // One LFSR step per bit taken
  task automatic rand_bits(input int nbits, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < nbits; i++) begin
      value = {value[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("** Error at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  // Put a write on the bus and queue what the controller must see
  task automatic drive_write(input wb_addr_t addr, input wb_data_t data, input wb_sel_t sel);
    sdr_cmd_t cmd;
    wr_beat_t beat;
    wb_cyc_i  = 1'b1;
    wb_stb_i  = 1'b1;
    wb_we_i   = 1'b1;
    wb_addr_i = addr;
    wb_dat_i  = data;
    wb_sel_i  = sel;
    cmd.len   = burst_len_t'(`WB2SDRC_BURST_LEN);
    cmd.wr_n  = 1'b0;
    cmd.addr  = addr;
    beat.en_n = ~sel;
    beat.data = data;
    exp_cmd_q.push_back(cmd);
    exp_beat_q.push_back(beat);
  endtask

  task automatic drive_read(input wb_addr_t addr);
    sdr_cmd_t cmd;
    wb_cyc_i  = 1'b1;
    wb_stb_i  = 1'b1;
    wb_we_i   = 1'b0;
    wb_addr_i = addr;
    cmd.len   = burst_len_t'(`WB2SDRC_BURST_LEN);
    cmd.wr_n  = 1'b1;
    cmd.addr  = addr;
    exp_cmd_q.push_back(cmd);
  endtask

  // Entered at a falling edge with the request driven and left at a falling edge
  task automatic wait_for_ack(output int cycles, output wb_data_t rdata);
    logic acked;
    acked  = 1'b0;
    cycles = 0;
    rdata  = '0;
    while (!acked && cycles < TIMEOUT) begin
      #SAMPLE_DLY;
      if (wb_ack_o) begin
        acked = 1'b1;
        rdata = wb_dat_o;
      end else begin
        cycles++;
      end
      @(negedge sdram_clk);
    end
    // Transfer done at the rising edge just passed
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    if (!acked) begin
      timeout_count++;
      $display("Timeout: no Wishbone acknowledge within %0d cycles at %0t", TIMEOUT, $time);
    end
  endtask

  task automatic wb_write(input wb_addr_t addr, input wb_data_t data, input wb_sel_t sel,
                          output int cycles);
    wb_data_t unused;
    @(negedge sdram_clk);
    drive_write(addr, data, sel);
    wait_for_ack(cycles, unused);
  endtask

  // Controller takes the head command and its beat
  task automatic pop_command();
    sdr_cmd_t cmd;
    wr_beat_t beat;
    int       waited;
    waited = 0;
    #SAMPLE_DLY;
    while (!sdr_req_o && waited < TIMEOUT) begin
      @(negedge sdram_clk);
      #SAMPLE_DLY;
      waited++;
    end
    if (!sdr_req_o) begin
      timeout_count++;
      $display("Timeout: no controller request within %0d cycles at %0t", TIMEOUT, $time);
      @(negedge sdram_clk);
    end else if (exp_cmd_q.size() == 0) begin
      err_count++;
      $display("Controller request at %0t with no command expected", $time);
      @(negedge sdram_clk);
    end else begin
      cmd = exp_cmd_q.pop_front();
      check_value("sdr_req_addr_o", sdr_req_addr_o, cmd.addr);
      check_value("sdr_req_wr_n_o", sdr_req_wr_n_o, cmd.wr_n);
      check_value("sdr_req_len_o", sdr_req_len_o, cmd.len);
      if (!cmd.wr_n) begin
        beat = exp_beat_q.pop_front();
        check_value("sdr_wr_data_o", sdr_wr_data_o, beat.data);
        check_value("sdr_wr_en_n_o", sdr_wr_en_n_o, beat.en_n);
      end
      @(negedge sdram_clk);
      sdr_req_ack_i = 1'b1;
      sdr_wr_next_i = ~cmd.wr_n;
      @(negedge sdram_clk);
      sdr_req_ack_i = 1'b0;
      sdr_wr_next_i = 1'b0;
    end
  endtask

  // Master holds a read while the controller drains the queue and answers
  task automatic read_round_trip(input wb_addr_t addr, input wb_data_t word,
                                 input int n_writes);
    int       cycles;
    wb_data_t rdata;
    rd_valid_sent = 1'b0;
    fork
      begin
        @(negedge sdram_clk);
        drive_read(addr);
        wait_for_ack(cycles, rdata);
        check_value("read ack after data return", rd_valid_sent, 1'b1);
        check_value("wb_dat_o", rdata, word);
      end
      begin
        @(negedge sdram_clk);
        repeat (n_writes + 1) pop_command();
        // Read command gone so no second one and no ack yet
        repeat (3) begin
          #SAMPLE_DLY;
          check_value("wb_ack_o before read data", wb_ack_o, 1'b0);
          check_value("sdr_req_o while read pending", sdr_req_o, 1'b0);
          @(negedge sdram_clk);
        end
        rd_valid_sent  = 1'b1;
        sdr_rd_valid_i = 1'b1;
        sdr_rd_data_i  = word;
        // Word lands in the read queue at the next rising edge
        #SAMPLE_DLY;
        check_value("wb_ack_o with read data arriving", wb_ack_o, 1'b0);
        @(negedge sdram_clk);
        sdr_rd_valid_i = 1'b0;
        #SAMPLE_DLY;
        check_value("wb_ack_o one cycle after read data", wb_ack_o, 1'b1);
      end
    join
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  task automatic test_reset();
    wb_clk_i = 1'b1;
    repeat (RESET_CYCLES) begin
      @(negedge sdram_clk);
      check_value("wb_ack_o in reset", wb_ack_o, 1'b0);
      check_value("sdr_req_o in reset", sdr_req_o, 1'b0);
    end
    wb_clk_i = 1'b0;
    repeat (3) begin
      #SAMPLE_DLY;
      check_value("wb_ack_o after reset", wb_ack_o, 1'b0);
      check_value("sdr_req_o after reset", sdr_req_o, 1'b0);
      @(negedge sdram_clk);
    end
  endtask

  task automatic test_single_write();
    int          cycles;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] sel;
    rand_bits(`WB2SDRC_AW, addr);
    rand_bits(`WB2SDRC_DW, data);
    rand_bits(`WB2SDRC_DW / 8, sel);
    wb_write(addr[`WB2SDRC_AW-1:0], data, sel[`WB2SDRC_DW/8-1:0], cycles);
    check_value("write ack latency", cycles, 0);
    // Request up right after the acked edge
    #SAMPLE_DLY;
    check_value("sdr_req_o after write ack", sdr_req_o, 1'b1);
    @(negedge sdram_clk);
    pop_command();
    #SAMPLE_DLY;
    check_value("sdr_req_o after command ack", sdr_req_o, 1'b0);
    @(negedge sdram_clk);
  endtask

  task automatic test_single_read();
    logic [31:0] addr;
    logic [31:0] word;
    rand_bits(`WB2SDRC_AW, addr);
    rand_bits(`WB2SDRC_DW, word);
    read_round_trip(addr[`WB2SDRC_AW-1:0], word, 0);
  endtask

  task automatic test_back_pressure();
    int          cycles;
    wb_data_t    unused;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] sel;
    // Fill the command queue
    repeat (`WB2SDRC_CMD_DEPTH) begin
      rand_bits(`WB2SDRC_AW, addr);
      rand_bits(`WB2SDRC_DW, data);
      rand_bits(`WB2SDRC_DW / 8, sel);
      wb_write(addr[`WB2SDRC_AW-1:0], data, sel[`WB2SDRC_DW/8-1:0], cycles);
      check_value("write ack with room", cycles, 0);
    end
    rand_bits(`WB2SDRC_AW, addr);
    rand_bits(`WB2SDRC_DW, data);
    rand_bits(`WB2SDRC_DW / 8, sel);
    @(negedge sdram_clk);
    drive_write(addr[`WB2SDRC_AW-1:0], data, sel[`WB2SDRC_DW/8-1:0]);
    repeat (5) begin
      #SAMPLE_DLY;
      check_value("wb_ack_o with command queue full", wb_ack_o, 1'b0);
      @(negedge sdram_clk);
    end
    pop_command();
    wait_for_ack(cycles, unused);
    check_value("write ack after one pop", cycles, 0);
    repeat (`WB2SDRC_CMD_DEPTH) pop_command();
    #SAMPLE_DLY;
    check_value("sdr_req_o after drain", sdr_req_o, 1'b0);
    @(negedge sdram_clk);
  endtask

  task automatic test_mixed_traffic();
    int          cycles;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] sel;
    repeat (3) begin
      rand_bits(`WB2SDRC_AW, addr);
      rand_bits(`WB2SDRC_DW, data);
      rand_bits(`WB2SDRC_DW / 8, sel);
      wb_write(addr[`WB2SDRC_AW-1:0], data, sel[`WB2SDRC_DW/8-1:0], cycles);
      check_value("mixed write ack latency", cycles, 0);
    end
    rand_bits(`WB2SDRC_AW, addr);
    rand_bits(`WB2SDRC_DW, data);
    read_round_trip(addr[`WB2SDRC_AW-1:0], data, 3);
    check_value("commands left over", exp_cmd_q.size(), 0);
    check_value("beats left over", exp_beat_q.size(), 0);
  endtask

  // ----------------------------------------
  // Sequence
  // ----------------------------------------
  initial begin
    lfsr_q         = 32'h52a92db8;
    check_count    = 0;
    err_count      = 0;
    timeout_count  = 0;
    rd_valid_sent  = 1'b0;
    wb_clk_i       = 1'b1;
    wb_cyc_i       = 1'b0;
    wb_stb_i       = 1'b0;
    wb_we_i        = 1'b0;
    wb_addr_i      = '0;
    wb_dat_i       = '0;
    wb_sel_i       = '0;
    sdr_req_ack_i  = 1'b0;
    sdr_wr_next_i  = 1'b0;
    sdr_rd_valid_i = 1'b0;
    sdr_rd_data_i  = '0;
    test_reset();
    test_single_write();
    test_single_read();
    test_back_pressure();
    test_mixed_traffic();
    $display("Checks: %0d, errors: %0d, timeouts: %0d", check_count, err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Whole run bound
  initial begin
    #(CLK_PERIOD * WATCHDOG);
    $display("Simulation did not finish within %0d clock cycles", WATCHDOG);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// File: dv/wb2sdrc_assert.sv
// Bridge queue protocol assertions
`timescale 1ns/100ps

module wb2sdrc_assert (
  input logic                      sdram_clk,
  input logic                      wb_clk_i,
  // Command queue
  input logic                      cmd_push_i,
  input logic                      cmd_full_i,
  input logic                      cmd_pop_i,
  input logic                      cmd_empty_i,
  // Write data queue
  input logic                      wr_push_i,
  input logic                      wr_full_i,
  input logic                      wr_pop_i,
  input logic                      wr_empty_i,
  // Read data queue
  input logic                      rd_push_i,
  input logic                      rd_full_i,
  input logic                      rd_pop_i,
  input logic                      rd_empty_i,
  // Read command push and read tracking state
  input logic                      rd_cmd_i,
  input wb2sdrc_pkg::ctrl_state_e  state_i
);

  import wb2sdrc_pkg::*;

  // Read outstanding from its command push until the acked pop
  logic rd_open_q;

  always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
    if (wb_clk_i) begin
      rd_open_q <= 1'b0;
    end else if (rd_cmd_i) begin
      rd_open_q <= 1'b1;
    end else if (rd_pop_i) begin
      rd_open_q <= 1'b0;
    end
  end

  // ----------------------------------------
  // Overflow
  // ----------------------------------------
  a_cmd_overflow: assert property (@(posedge sdram_clk) disable iff (wb_clk_i)
    !(cmd_push_i && cmd_full_i)) else $error("Push to full command queue");
  a_wr_overflow: assert property (@(posedge sdram_clk) disable iff (wb_clk_i)
    !(wr_push_i && wr_full_i)) else $error("Push to full write data queue");
  a_rd_overflow: assert property (@(posedge sdram_clk) disable iff (wb_clk_i)
    !(rd_push_i && rd_full_i)) else $error("Push to full read data queue");

  // ----------------------------------------
  // Underflow
  // ----------------------------------------
  a_cmd_underflow: assert property (@(posedge sdram_clk) disable iff (wb_clk_i)
    !(cmd_pop_i && cmd_empty_i)) else $error("Pop of empty command queue");
  a_wr_underflow: assert property (@(posedge sdram_clk) disable iff (wb_clk_i)
    !(wr_pop_i && wr_empty_i)) else $error("Pop of empty write data queue");
  a_rd_underflow: assert property (@(posedge sdram_clk) disable iff (wb_clk_i)
    !(rd_pop_i && rd_empty_i)) else $error("Pop of empty read data queue");

  // ----------------------------------------
  // Read tracking
  // ----------------------------------------
  // FSM waits exactly while a read is outstanding
  a_state_track: assert property (@(posedge sdram_clk) disable iff (wb_clk_i)
    ((state_i == CTRL_READ_WAIT) == rd_open_q)) else $error("Read state out of step");

  // Second read command while the first is still waiting for data
  a_double_read: assert property (@(posedge sdram_clk) disable iff (wb_clk_i)
    !(rd_cmd_i && rd_open_q)) else $error("Read command while read pending");

endmodule

// File: src/sync_fifo.sv
// Synchronous show-ahead FIFO
`timescale 1ns/100ps

module sync_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 4
) (
  input  logic             sdram_clk,
  input  logic             wb_clk_i,
  // Write side
  input  logic             push_i,
  input  logic [WIDTH-1:0] push_data_i,
  // Read side, head entry always visible
  input  logic             pop_i,
  output logic [WIDTH-1:0] pop_data_o,
  // Status
  output logic             full_o,
  output logic             empty_o
);

  // ----------------------------------------
  // Local sizes
  // ----------------------------------------
  // Pointer needs at least one bit even for a single entry
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  // Count must reach DEPTH itself
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Storage array
  logic [WIDTH-1:0] mem_q [DEPTH];

  // Pointers and fill level
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic [CNT_W-1:0] count_d;

  // Registered flags
  logic full_q;
  logic empty_q;

  // Pointer advance with wrap at DEPTH-1
  // Depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // ----------------------------------------
  // Storage
  // ----------------------------------------
  // Write at the tail
  always_ff @(posedge sdram_clk) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // Head entry presented without a read cycle
  assign pop_data_o = mem_q[rd_ptr_q];

  // ----------------------------------------
  // Pointers
  // ----------------------------------------
  always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
    if (wb_clk_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      // Tail moves on push
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      // Head moves on pop
      if (pop_i) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
    end
  end

  // ----------------------------------------
  // Fill level and flags
  // ----------------------------------------
  // Next count, push and pop together leave it unchanged
  always_comb begin
    count_d = count_q;
    case ({push_i, pop_i})
      2'b10:   count_d = count_q + 1'b1;
      2'b01:   count_d = count_q - 1'b1;
      default: count_d = count_q;
    endcase
  end

  // Flags come from the next count so they are valid right after the edge
  always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
    if (wb_clk_i) begin
      count_q <= '0;
      full_q  <= 1'b0;
      empty_q <= 1'b1;
    end else begin
      count_q <= count_d;
      full_q  <= (count_d == CNT_W'(DEPTH));
      empty_q <= (count_d == '0);
    end
  end

  assign full_o  = full_q;
  assign empty_o = empty_q;

endmodule

// File: src/wb2sdrc.sv
// Wishbone to SDRAM controller bridge
`timescale 1ns/100ps
`include "wb2sdrc_config.svh"

module wb2sdrc (
  input  logic                     sdram_clk,
  input  logic                     wb_clk_i,
  // ----------------------------------------
  // Wishbone slave
  // ----------------------------------------
  input  logic                     wb_cyc_i,
  input  logic                     wb_stb_i,
  // 1 write, 0 read
  input  logic                     wb_we_i,
  input  wb2sdrc_pkg::wb_addr_t    wb_addr_i,
  input  wb2sdrc_pkg::wb_data_t    wb_dat_i,
  input  wb2sdrc_pkg::wb_sel_t     wb_sel_i,
  output logic                     wb_ack_o,
  output wb2sdrc_pkg::wb_data_t    wb_dat_o,
  // ----------------------------------------
  // SDRAM controller request side
  // ----------------------------------------
  // Level, high while a command waits
  output logic                     sdr_req_o,
  output wb2sdrc_pkg::wb_addr_t    sdr_req_addr_o,
  // 0 write, 1 read
  output logic                     sdr_req_wr_n_o,
  output wb2sdrc_pkg::burst_len_t  sdr_req_len_o,
  // Command taken
  input  logic                     sdr_req_ack_i,
  // Write beat taken
  input  logic                     sdr_wr_next_i,
  output wb2sdrc_pkg::wb_sel_t     sdr_wr_en_n_o,
  output wb2sdrc_pkg::wb_data_t    sdr_wr_data_o,
  // Read data return
  input  logic                     sdr_rd_valid_i,
  input  wb2sdrc_pkg::wb_data_t    sdr_rd_data_i
);

  import wb2sdrc_pkg::*;

  // ----------------------------------------
  // Internal wires
  // ----------------------------------------
  // Queue strobes from the bus control
  logic cmd_push;
  logic wr_push;
  logic rd_pop;

  // Queue status
  logic cmd_full;
  logic cmd_empty;
  logic wr_full;
  logic wr_empty;
  logic rd_full;
  logic rd_empty;

  // Queue entries in and at the head
  sdr_cmd_t cmd_in;
  sdr_cmd_t cmd_head;
  wr_beat_t beat_in;
  wr_beat_t beat_head;

  // ----------------------------------------
  // Entry packing
  // ----------------------------------------
  // Single transfer bursts only
  assign cmd_in.len  = burst_len_t'(`WB2SDRC_BURST_LEN);
  assign cmd_in.wr_n = ~wb_we_i;
  assign cmd_in.addr = wb_addr_i;

  // Byte enables go out active low
  assign beat_in.en_n = ~wb_sel_i;
  assign beat_in.data = wb_dat_i;

  // Request bundle from the command head
  assign sdr_req_o      = ~cmd_empty;
  assign sdr_req_len_o  = cmd_head.len;
  assign sdr_req_wr_n_o = cmd_head.wr_n;
  assign sdr_req_addr_o = cmd_head.addr;

  // Write beat from the data head
  assign sdr_wr_en_n_o = beat_head.en_n;
  assign sdr_wr_data_o = beat_head.data;

  // ----------------------------------------
  // Bus control
  // ----------------------------------------
  wb_bus_ctrl u_ctrl (
    .sdram_clk  (sdram_clk),
    .wb_clk_i   (wb_clk_i),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .cmd_full_i (cmd_full),
    .wr_full_i  (wr_full),
    .rd_empty_i (rd_empty),
    .wb_ack_o   (wb_ack_o),
    .cmd_push_o (cmd_push),
    .wr_push_o  (wr_push),
    .rd_pop_o   (rd_pop)
  );

  // ----------------------------------------
  // Queues
  // ----------------------------------------
  // Commands, popped by the controller ack
  sync_fifo #(
    .WIDTH ($bits(sdr_cmd_t)),
    .DEPTH (`WB2SDRC_CMD_DEPTH)
  ) u_cmd_fifo (
    .sdram_clk   (sdram_clk),
    .wb_clk_i    (wb_clk_i),
    .push_i      (cmd_push),
    .push_data_i (cmd_in),
    .pop_i       (sdr_req_ack_i),
    .pop_data_o  (cmd_head),
    .full_o      (cmd_full),
    .empty_o     (cmd_empty)
  );

  // Write beats, popped by next-write
  sync_fifo #(
    .WIDTH ($bits(wr_beat_t)),
    .DEPTH (`WB2SDRC_WR_DEPTH)
  ) u_wr_fifo (
    .sdram_clk   (sdram_clk),
    .wb_clk_i    (wb_clk_i),
    .push_i      (wr_push),
    .push_data_i (beat_in),
    .pop_i       (sdr_wr_next_i),
    .pop_data_o  (beat_head),
    .full_o      (wr_full),
    .empty_o     (wr_empty)
  );

  // Read words, head drives the Wishbone data bus
  sync_fifo #(
    .WIDTH ($bits(wb_data_t)),
    .DEPTH (`WB2SDRC_RD_DEPTH)
  ) u_rd_fifo (
    .sdram_clk   (sdram_clk),
    .wb_clk_i    (wb_clk_i),
    .push_i      (sdr_rd_valid_i),
    .push_data_i (sdr_rd_data_i),
    .pop_i       (rd_pop),
    .pop_data_o  (wb_dat_o),
    .full_o      (rd_full),
    .empty_o     (rd_empty)
  );

endmodule

// File: src/wb2sdrc_config.svh
// Wishbone to SDRAM bridge configuration
`ifndef WB2SDRC_CONFIG_SVH
`define WB2SDRC_CONFIG_SVH

// ----------------------------------------
// Bus widths
// ----------------------------------------
// Application address width
`define WB2SDRC_AW 26
// Data width, byte selects follow from it
`define WB2SDRC_DW 32
// Width of the controller burst length field
`define WB2SDRC_BLW 9

// Length sent with every command, zero means one transfer
`define WB2SDRC_BURST_LEN 0

// ----------------------------------------
// Queue depths
// ----------------------------------------
`define WB2SDRC_CMD_DEPTH 4
`define WB2SDRC_WR_DEPTH 8
// Small, only one read is ever outstanding
`define WB2SDRC_RD_DEPTH 4

`endif

// File: src/wb2sdrc_pkg.sv
// Wishbone to SDRAM bridge types
`include "wb2sdrc_config.svh"

package wb2sdrc_pkg;

  // ----------------------------------------
  // Vector types
  // ----------------------------------------
  // Application word address
  typedef logic [`WB2SDRC_AW-1:0] wb_addr_t;
  // Data word on both sides of the bridge
  typedef logic [`WB2SDRC_DW-1:0] wb_data_t;
  // Byte select, active high on Wishbone and active low to the controller
  typedef logic [`WB2SDRC_DW/8-1:0] wb_sel_t;
  // Controller burst length field
  typedef logic [`WB2SDRC_BLW-1:0] burst_len_t;

  // ----------------------------------------
  // Queue entries
  // ----------------------------------------
  // Command queue entry
  // Field order matches the controller request bundle
  typedef struct packed {
    burst_len_t len;
    // 0 write, 1 read
    logic       wr_n;
    wb_addr_t   addr;
  } sdr_cmd_t;

  // Write data queue entry
  typedef struct packed {
    // Active low byte enables
    wb_sel_t  en_n;
    wb_data_t data;
  } wr_beat_t;

  // ----------------------------------------
  // Read tracking FSM
  // ----------------------------------------
  // Idle until a read command is queued
  // Wait holds off further read commands until the data is acked
  typedef enum logic {
    CTRL_IDLE,
    CTRL_READ_WAIT
  } ctrl_state_e;

endpackage

// File: src/wb_bus_ctrl.sv
// Wishbone slave acknowledge control
`timescale 1ns/100ps

module wb_bus_ctrl (
  input  logic sdram_clk,
  input  logic wb_clk_i,
  // Wishbone request qualifiers
  input  logic wb_cyc_i,
  input  logic wb_stb_i,
  input  logic wb_we_i,
  // Queue status
  input  logic cmd_full_i,
  input  logic wr_full_i,
  input  logic rd_empty_i,
  // Wishbone acknowledge
  output logic wb_ack_o,
  // Queue strobes
  output logic cmd_push_o,
  output logic wr_push_o,
  output logic rd_pop_o
);

  import wb2sdrc_pkg::*;

  // ----------------------------------------
  // Cycle decode
  // ----------------------------------------
  // Valid bus cycle
  logic wb_req;
  // Write and read phases of that cycle
  logic wr_phase;
  logic rd_phase;

  // Read tracking state
  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // Room for a write in both queues
  logic wr_room;
  // Read command may be queued now
  logic rd_cmd_ok;
  // Returned read word ready for the master
  logic rd_data_ok;

  assign wb_req   = wb_cyc_i & wb_stb_i;
  assign wr_phase = wb_req & wb_we_i;
  assign rd_phase = wb_req & ~wb_we_i;

  // A write needs one command slot and one beat slot
  assign wr_room = ~cmd_full_i & ~wr_full_i;

  // Only one read in flight
  assign rd_cmd_ok = rd_phase & ~cmd_full_i & (state_q == CTRL_IDLE);

  // Data only counts once our own read command is out
  assign rd_data_ok = rd_phase & ~rd_empty_i & (state_q == CTRL_READ_WAIT);

  // ----------------------------------------
  // Acknowledge
  // ----------------------------------------
  // Writes ack in the request cycle when there is room
  // Reads ack when the returned word is at the read queue head
  always_comb begin
    if (wr_phase) begin
      wb_ack_o = wr_room;
    end else if (rd_phase) begin
      wb_ack_o = rd_data_ok;
    end else begin
      wb_ack_o = 1'b0;
    end
  end

  // ----------------------------------------
  // Queue strobes
  // ----------------------------------------
  // Command push
  // Write pushes with its ack, read pushes once before waiting
  assign cmd_push_o = wr_phase ? wb_ack_o : rd_cmd_ok;

  // Beat goes with every acked write
  assign wr_push_o = wr_phase & wb_ack_o;

  // Acked read consumes the returned word
  assign rd_pop_o = rd_phase & wb_ack_o;

  // ----------------------------------------
  // Read tracking FSM
  // ----------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      CTRL_IDLE: begin
        // Read command accepted into the queue
        if (rd_cmd_ok) begin
          state_d = CTRL_READ_WAIT;
        end
      end
      CTRL_READ_WAIT: begin
        // Data handed to the master
        if (rd_pop_o) begin
          state_d = CTRL_IDLE;
        end
      end
      default: begin
        state_d = CTRL_IDLE;
      end
    endcase
  end

  always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
    if (wb_clk_i) begin
      state_q <= CTRL_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// File: verilog.f
+incdir+src
src/wb2sdrc_pkg.sv
src/sync_fifo.sv
src/wb_bus_ctrl.sv
src/wb2sdrc.sv
dv/wb2sdrc_assert.sv
dv/tb_wb2sdrc.sv
